// File: common/ddrom_consts.svh
`ifndef DDROM_CONSTS_SVH
`define DDROM_CONSTS_SVH

// Loader byte addresses of the ROM regions
`define BANK_ADDR   22'h00_0000
`define SND_ADDR    22'h02_8000
`define CHAR_ADDR   22'h08_0000
`define SCRZW_ADDR  22'h09_0000
`define OBJWZ_ADDR  22'h0D_0000

// Everything from here up goes to the PROM strobe
`define PROM_ADDR   22'h19_0000

// Scroll and object data are moved in SDRAM (16-bit word addresses)
`define SCR_SDRAM   22'h06_0000
`define OBJ_SDRAM   22'h08_0000

// Word offsets added by the arbiter to each slot request
`define MAIN_OFFSET (`BANK_ADDR >> 1)
`define SND_OFFSET  (`SND_ADDR >> 1)   // 0x14000
`define CHAR_OFFSET (`CHAR_ADDR >> 1)  // 0x40000
`define OBJ_OFFSET  `OBJ_SDRAM

// Slot address widths
// 8-bit slots are byte addressed, obj is 16-bit word addressed
`define MAIN_AW     18
`define SND_AW      15
`define CHAR_AW     16
`define OBJ_AW      18

// Game reset hold after the loader finishes
`define RST_TAIL    2

`endif

// File: common/ddrom_pkg.sv
package ddrom_pkg;

    // Byte address as sent by the loader
    typedef logic [21:0] byte_addr_t;

    // SDRAM address, counts 16-bit words
    typedef logic [21:0] sdram_addr_t;

    // Two consecutive SDRAM words, lower address in the low half
    typedef logic [31:0] sdram_word_t;

    typedef logic [7:0]  rom_byte_t;
    typedef logic [15:0] rom_half_t;

    // Slot owning the SDRAM access
    typedef logic [1:0]  slot_idx_t;

    // SDRAM access sequencing
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,   // sdram_req held high
        ARB_WAIT_DATA
    } arb_state_t;

endpackage

// File: ddrom.f
+incdir+common
common/ddrom_pkg.sv
download/rom_download.sv
fetch/rom_slot.sv
fetch/rom_arbiter.sv
hdl/ddrom_top.sv
tests/ddrom_tb.sv

// File: download/rom_download.sv
`timescale 1ns/10ps
`include "ddrom_consts.svh"

module rom_download import ddrom_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    input  byte_addr_t  ioctl_addr,
    input  rom_byte_t   ioctl_data,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output sdram_addr_t prog_addr,
    output rom_byte_t   prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    output logic        prom_we,
    output logic        game_rst
);

    localparam int TW = $clog2(`RST_TAIL + 1);

    sdram_addr_t    remap_addr;
    logic           is_prom;
    logic [TW-1:0]  tail_cnt;

    // Region remap of the loader address
    always_comb begin
        is_prom = 1'b0;
        if (ioctl_addr >= `PROM_ADDR) begin
            is_prom    = 1'b1;
            remap_addr = ioctl_addr - `PROM_ADDR;   // PROM byte index
        end else if (ioctl_addr >= `OBJWZ_ADDR) begin
            remap_addr = `OBJ_SDRAM + ((ioctl_addr - `OBJWZ_ADDR) >> 1);
        end else if (ioctl_addr >= `SCRZW_ADDR) begin
            remap_addr = `SCR_SDRAM + ((ioctl_addr - `SCRZW_ADDR) >> 1);
        end else begin
            remap_addr = (ioctl_addr - `BANK_ADDR) >> 1;    // CPU and char ROMs in place
        end
    end

    // Write strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= ioctl_wr && is_prom;
            if (sdram_ack)
                prog_we <= 1'b0;
            if (ioctl_wr && !is_prom)
                prog_we <= 1'b1;    // held until the SDRAM takes it
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            prog_addr <= remap_addr;
            prog_data <= ioctl_data;
            // Active low, even byte goes to the low lane
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    // Game reset, stretched past the end of the download
    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            game_rst <= 1'b1;
            tail_cnt <= TW'(`RST_TAIL);
        end else begin
            if (tail_cnt != '0)
                tail_cnt <= tail_cnt - 1'b1;
            game_rst <= tail_cnt > 1;   // drops as the count reaches zero
        end
    end

endmodule

// File: fetch/rom_arbiter.sv
`timescale 1ns/10ps
`include "ddrom_consts.svh"

module rom_arbiter import ddrom_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // Main CPU slot, highest priority
    input  logic        main_req,
    input  sdram_addr_t main_req_addr,
    output logic        main_grant,
    output logic        main_fill,
    // Sound CPU slot
    input  logic        snd_req,
    input  sdram_addr_t snd_req_addr,
    output logic        snd_grant,
    output logic        snd_fill,
    // Character slot
    input  logic        char_req,
    input  sdram_addr_t char_req_addr,
    output logic        char_grant,
    output logic        char_fill,
    // Object slot, lowest priority
    input  logic        obj_req,
    input  sdram_addr_t obj_req_addr,
    output logic        obj_grant,
    output logic        obj_fill,
    output sdram_word_t fill_data,
    // SDRAM
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_word_t data_read
);

    localparam slot_idx_t SLOT_MAIN = 2'd0;
    localparam slot_idx_t SLOT_SND  = 2'd1;
    localparam slot_idx_t SLOT_CHAR = 2'd2;
    localparam slot_idx_t SLOT_OBJ  = 2'd3;

    arb_state_t  state;
    slot_idx_t   pick;
    slot_idx_t   owner;     // Slot of the access in flight
    sdram_addr_t pick_addr;
    logic        any_req;
    logic        take;
    logic        data_in;
    logic [3:0]  fill_q;

    // Fixed priority pick
    always_comb begin
        any_req = main_req || snd_req || char_req || obj_req;
        if (main_req)
            pick = SLOT_MAIN;
        else if (snd_req)
            pick = SLOT_SND;
        else if (char_req)
            pick = SLOT_CHAR;
        else
            pick = SLOT_OBJ;
    end

    // SDRAM location of the picked slot
    always_comb begin
        case (pick)
            SLOT_MAIN: pick_addr = `MAIN_OFFSET + main_req_addr;
            SLOT_SND:  pick_addr = `SND_OFFSET  + snd_req_addr;
            SLOT_CHAR: pick_addr = `CHAR_OFFSET + char_req_addr;
            default:   pick_addr = `OBJ_OFFSET  + obj_req_addr;
        endcase
    end

    assign take    = (state == ARB_IDLE) && any_req;
    assign data_in = (state == ARB_WAIT_DATA) && data_rdy;

    // Grant lasts the single idle cycle the request is taken in
    assign main_grant = take && (pick == SLOT_MAIN);
    assign snd_grant  = take && (pick == SLOT_SND);
    assign char_grant = take && (pick == SLOT_CHAR);
    assign obj_grant  = take && (pick == SLOT_OBJ);

    assign main_fill = fill_q[SLOT_MAIN];
    assign snd_fill  = fill_q[SLOT_SND];
    assign char_fill = fill_q[SLOT_CHAR];
    assign obj_fill  = fill_q[SLOT_OBJ];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
            fill_q    <= '0;
        end else begin
            fill_q <= '0;
            case (state)
                ARB_IDLE: begin
                    if (any_req) begin
                        sdram_req <= 1'b1;
                        state     <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        fill_q <= 4'b0001 << owner;   // Word back to its slot
                        state  <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            owner      <= pick;
            sdram_addr <= {pick_addr[21:1], 1'b0};
        end
        if (data_in)
            fill_data <= data_read;
    end

endmodule

// File: fetch/rom_slot.sv
`timescale 1ns/10ps

module rom_slot import ddrom_pkg::*; #(
    parameter int AW = 18,  // Slot address width
    parameter int DW = 8    // 8 or 16
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic [DW-1:0] data,
    output logic          ok,
    output logic          req,
    output sdram_addr_t   req_addr,
    input  logic          grant,
    input  logic          fill,
    input  sdram_word_t   fill_data
);

    // Address bits that pick a lane inside the cached 32-bit word
    localparam int LSB = (DW == 8) ? 2 : 1;
    localparam int TW  = AW - LSB;

    sdram_word_t     cache_word;
    logic [TW-1:0]   cache_tag;
    logic [TW-1:0]   pend_tag;
    logic            valid;
    logic            waiting;   // Access granted, fill not back yet
    logic            armed;
    logic [TW-1:0]   addr_tag;
    logic [LSB-1:0]  lane;
    logic            hit;

    assign addr_tag = addr[AW-1:LSB];
    assign lane     = addr[LSB-1:0];
    assign hit      = valid && (cache_tag == addr_tag);

    // Hit answers in the same cycle
    assign ok   = cs && hit;
    assign data = cache_word[lane*DW +: DW];

    // Miss request, one at a time per slot
    assign req      = cs && !hit && armed && !waiting;
    assign req_addr = sdram_addr_t'({addr_tag, 1'b0});  // 32-bit aligned word address

    always_ff @(posedge clk) begin
        if (reset) begin
            valid   <= 1'b0;
            waiting <= 1'b0;
            armed   <= 1'b0;
        end else begin
            armed <= 1'b1;  // No requests while reset is up
            if (grant)
                waiting <= 1'b1;
            if (fill) begin
                valid   <= 1'b1;
                waiting <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant)
            pend_tag <= addr_tag;   // cs/addr may move before the data returns
        if (fill) begin
            cache_word <= fill_data;
            cache_tag  <= pend_tag;
        end
    end

endmodule

// File: hdl/ddrom_top.sv
`timescale 1ns/10ps
`include "ddrom_consts.svh"

module ddrom_top import ddrom_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // Loader
    input  logic                  downloading,
    input  byte_addr_t            ioctl_addr,
    input  rom_byte_t             ioctl_data,
    input  logic                  ioctl_wr,
    output sdram_addr_t           prog_addr,
    output rom_byte_t             prog_data,
    output logic [1:0]            prog_mask,
    output logic                  prog_we,
    output logic                  prom_we,
    output logic                  game_rst,
    // SDRAM read side
    output logic                  sdram_req,
    output sdram_addr_t           sdram_addr,
    input  logic                  sdram_ack,
    input  logic                  data_rdy,
    input  sdram_word_t           data_read,
    // Main CPU ROM
    input  logic                  main_cs,
    input  logic [`MAIN_AW-1:0]   main_addr,
    output rom_byte_t             main_data,
    output logic                  main_ok,
    // Sound CPU ROM
    input  logic                  snd_cs,
    input  logic [`SND_AW-1:0]    snd_addr,
    output rom_byte_t             snd_data,
    output logic                  snd_ok,
    // Characters
    input  logic                  char_cs,
    input  logic [`CHAR_AW-1:0]   char_addr,
    output rom_byte_t             char_data,
    output logic                  char_ok,
    // Objects, 16-bit wide
    input  logic                  obj_cs,
    input  logic [`OBJ_AW-1:0]    obj_addr,
    output rom_half_t             obj_data,
    output logic                  obj_ok
);

    logic        main_req, snd_req, char_req, obj_req;
    logic        main_grant, snd_grant, char_grant, obj_grant;
    logic        main_fill, snd_fill, char_fill, obj_fill;
    sdram_addr_t main_req_addr, snd_req_addr, char_req_addr, obj_req_addr;
    sdram_word_t fill_data;

    rom_download u_download (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .game_rst    ( game_rst    )
    );

    rom_slot #(.AW(`MAIN_AW), .DW(8)) u_main (
        .clk       ( clk           ),
        .reset     ( game_rst      ),
        .cs        ( main_cs       ),
        .addr      ( main_addr     ),
        .data      ( main_data     ),
        .ok        ( main_ok       ),
        .req       ( main_req      ),
        .req_addr  ( main_req_addr ),
        .grant     ( main_grant    ),
        .fill      ( main_fill     ),
        .fill_data ( fill_data     )
    );

    rom_slot #(.AW(`SND_AW), .DW(8)) u_snd (
        .clk       ( clk           ),
        .reset     ( game_rst      ),
        .cs        ( snd_cs        ),
        .addr      ( snd_addr      ),
        .data      ( snd_data      ),
        .ok        ( snd_ok        ),
        .req       ( snd_req       ),
        .req_addr  ( snd_req_addr  ),
        .grant     ( snd_grant     ),
        .fill      ( snd_fill      ),
        .fill_data ( fill_data     )
    );

    rom_slot #(.AW(`CHAR_AW), .DW(8)) u_char (
        .clk       ( clk           ),
        .reset     ( game_rst      ),
        .cs        ( char_cs       ),
        .addr      ( char_addr     ),
        .data      ( char_data     ),
        .ok        ( char_ok       ),
        .req       ( char_req      ),
        .req_addr  ( char_req_addr ),
        .grant     ( char_grant    ),
        .fill      ( char_fill     ),
        .fill_data ( fill_data     )
    );

    rom_slot #(.AW(`OBJ_AW), .DW(16)) u_obj (
        .clk       ( clk           ),
        .reset     ( game_rst      ),
        .cs        ( obj_cs        ),
        .addr      ( obj_addr      ),
        .data      ( obj_data      ),
        .ok        ( obj_ok        ),
        .req       ( obj_req       ),
        .req_addr  ( obj_req_addr  ),
        .grant     ( obj_grant     ),
        .fill      ( obj_fill      ),
        .fill_data ( fill_data     )
    );

    rom_arbiter u_arb (
        .clk           ( clk           ),
        .reset         ( game_rst      ),
        .main_req      ( main_req      ),
        .main_req_addr ( main_req_addr ),
        .main_grant    ( main_grant    ),
        .main_fill     ( main_fill     ),
        .snd_req       ( snd_req       ),
        .snd_req_addr  ( snd_req_addr  ),
        .snd_grant     ( snd_grant     ),
        .snd_fill      ( snd_fill      ),
        .char_req      ( char_req      ),
        .char_req_addr ( char_req_addr ),
        .char_grant    ( char_grant    ),
        .char_fill     ( char_fill     ),
        .obj_req       ( obj_req       ),
        .obj_req_addr  ( obj_req_addr  ),
        .obj_grant     ( obj_grant     ),
        .obj_fill      ( obj_fill      ),
        .fill_data     ( fill_data     ),
        .sdram_req     ( sdram_req     ),
        .sdram_addr    ( sdram_addr    ),
        .sdram_ack     ( sdram_ack     ),
        .data_rdy      ( data_rdy      ),
        .data_read     ( data_read     )
    );

endmodule

// File: tests/ddrom_tb.sv
`timescale 1ns/10ps
`include "ddrom_consts.svh"

module ddrom_tb import ddrom_pkg::*; ();

    localparam int CLK_NS       = 40;
    localparam int MAX_WAIT     = 40;   // Cycles allowed for one handshake
    localparam longint WATCHDOG_NS = 500 * 40 * CLK_NS;

    logic                clk, reset, downloading, ioctl_wr;
    byte_addr_t          ioctl_addr;
    rom_byte_t           ioctl_data, prog_data;
    sdram_addr_t         prog_addr, sdram_addr;
    logic [1:0]          prog_mask;
    logic                prog_we, prom_we, game_rst, sdram_req, sdram_ack, data_rdy;
    sdram_word_t         data_read;
    logic                main_cs, snd_cs, char_cs, obj_cs;
    logic                main_ok, snd_ok, char_ok, obj_ok;
    logic [`MAIN_AW-1:0] main_addr;
    logic [`SND_AW-1:0]  snd_addr;
    logic [`CHAR_AW-1:0] char_addr;
    logic [`OBJ_AW-1:0]  obj_addr;
    rom_byte_t           main_data, snd_data, char_data;
    rom_half_t           obj_data;
    logic [3:0]          oks;

    integer    seed = 40559;
    rom_byte_t image [byte_addr_t];      // Reference image by loader address
    rom_half_t sdram_mem [sdram_addr_t];

    assign oks = {obj_ok, char_ok, snd_ok, main_ok};

    ddrom_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        report_error("Watchdog timeout, the run did not finish in time");
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic rom_byte_t image_byte(input byte_addr_t a);
        return image.exists(a) ? image[a] : 8'h00;
    endfunction

    function automatic rom_half_t mem_word(input sdram_addr_t a);
        return sdram_mem.exists(a) ? sdram_mem[a] : 16'h0000;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input sdram_addr_t expected,
                              input sdram_addr_t actual);
        if (actual !== expected)
            report_error($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_byte(input string name, input rom_byte_t expected,
                              input rom_byte_t actual);
        if (actual !== expected)
            report_error($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_half(input string name, input rom_half_t expected,
                              input rom_half_t actual);
        if (actual !== expected)
            report_error($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            report_error($sformatf("Error: %s expected %b actual %b", name, expected, actual));
    endtask

    // SDRAM model with byte lane writes from the loader and two-word reads for the slots
    initial begin
        rom_half_t   w;
        sdram_addr_t ra;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (prog_we) begin
                w = mem_word(prog_addr);
                if (!prog_mask[0])
                    w[7:0] = prog_data;
                if (!prog_mask[1])
                    w[15:8] = prog_data;
                sdram_mem[prog_addr] = w;
                repeat (rand_below(3)) @(negedge clk);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
            end else if (sdram_req) begin
                ra = sdram_addr;
                repeat (rand_below(4)) @(negedge clk);   // 1 to 4 cycles to ack
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                repeat (1 + rand_below(5)) @(negedge clk);
                data_read = {mem_word(ra + 1'b1), mem_word(ra)};
                data_rdy  = 1'b1;
                @(negedge clk);
                data_rdy  = 1'b0;
            end
        end
    end

    task automatic write_byte(input byte_addr_t a, input rom_byte_t d);
        sdram_addr_t exp_addr;
        int          waited;
        if (a >= `PROM_ADDR)
            exp_addr = a - `PROM_ADDR;
        else if (a >= `OBJWZ_ADDR)
            exp_addr = `OBJ_SDRAM + (a - `OBJWZ_ADDR) / 2;
        else if (a >= `SCRZW_ADDR)
            exp_addr = `SCR_SDRAM + (a - `SCRZW_ADDR) / 2;
        else
            exp_addr = a / 2;
        image[a] = d;
        @(negedge clk);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        check_bit("game_rst in download", 1'b1, game_rst);
        check_addr("prog_addr", exp_addr, prog_addr);
        if (a >= `PROM_ADDR) begin
            check_bit("prom_we pulse", 1'b1, prom_we);
            check_bit("prog_we on prom write", 1'b0, prog_we);
            @(negedge clk);
            check_bit("prom_we one cycle", 1'b0, prom_we);
            check_bit("prog_we after prom write", 1'b0, prog_we);
        end else begin
            check_bit("prog_we", 1'b1, prog_we);
            check_bit("prom_we on sdram write", 1'b0, prom_we);
            check_byte("prog_data", d, prog_data);
            // Active low lanes, even byte in the low lane
            check_bit("prog_mask low lane", a[0], prog_mask[0]);
            check_bit("prog_mask high lane", !a[0], prog_mask[1]);
            waited = 0;
            while (prog_we) begin
                if (waited == MAX_WAIT)
                    report_error("Timeout waiting for the SDRAM write to finish");
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic drive_slots(input int slot, input logic [17:0] a, input logic on);
        main_cs   = on && (slot == 0);
        snd_cs    = on && (slot == 1);
        char_cs   = on && (slot == 2);
        obj_cs    = on && (slot == 3);
        main_addr = a;
        snd_addr  = a[`SND_AW-1:0];
        char_addr = a[`CHAR_AW-1:0];
        obj_addr  = a;
    endtask

    task automatic check_slot_data(input int slot, input logic [17:0] a);
        case (slot)
            0: check_byte("main read", image_byte(a), main_data);
            1: check_byte("sound read", image_byte(`SND_ADDR + a), snd_data);
            2: check_byte("char read", image_byte(`CHAR_ADDR + a), char_data);
            default: check_half("obj read", {image_byte(`OBJWZ_ADDR + 2 * a + 1),
                                             image_byte(`OBJWZ_ADDR + 2 * a)}, obj_data);
        endcase
    endtask

    task automatic read_slot(input int slot, input logic [17:0] a, input bit want_hit);
        int waited;
        @(negedge clk);
        drive_slots(slot, a, 1'b1);
        #(CLK_NS / 4);
        waited = 0;
        while (!oks[slot]) begin
            if (want_hit)
                report_error("Read in the cached word missed, ok stayed low");
            if (waited == MAX_WAIT)
                report_error("Timeout waiting for slot ok");
            @(negedge clk);
            #(CLK_NS / 4);
            waited++;
        end
        check_slot_data(slot, a);
        @(negedge clk);
        if (want_hit)
            check_bit("sdram_req on cache hit", 1'b0, sdram_req);
        drive_slots(slot, a, 1'b0);
    endtask

    // Main and obj miss in the same cycle and main goes first
    task automatic priority_read(input logic [17:0] pa, input logic [17:0] oa);
        int waited;
        @(negedge clk);
        drive_slots(0, pa, 1'b1);
        obj_cs   = 1'b1;
        obj_addr = oa;
        #(CLK_NS / 4);
        waited = 0;
        while (!sdram_req) begin
            if (waited == MAX_WAIT)
                report_error("Timeout waiting for sdram_req");
            @(negedge clk);
            #(CLK_NS / 4);
            waited++;
        end
        check_addr("priority sdram_addr", `MAIN_OFFSET + ((pa >> 2) << 1), sdram_addr);
        while (!(main_ok && obj_ok)) begin
            if (waited == 2 * MAX_WAIT)
                report_error("Timeout waiting for main and obj ok");
            @(negedge clk);
            #(CLK_NS / 4);
            waited++;
        end
        check_slot_data(0, pa);
        check_slot_data(3, oa);
        @(negedge clk);
        drive_slots(0, pa, 1'b0);
    endtask

    initial begin
        byte_addr_t  a;
        logic [17:0] ra;
        int          slot;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        drive_slots(0, '0, 1'b0);
        // All selects up so ok and req show the reset state of the caches
        main_cs = 1'b1;
        snd_cs  = 1'b1;
        char_cs = 1'b1;
        obj_cs  = 1'b1;
        repeat (16) @(negedge clk);
        check_bit("game_rst in reset", 1'b1, game_rst);
        check_bit("prog_we in reset", 1'b0, prog_we);
        check_bit("prom_we in reset", 1'b0, prom_we);
        check_bit("sdram_req in reset", 1'b0, sdram_req);
        check_bit("slot ok in reset", 1'b0, |oks);
        drive_slots(0, '0, 1'b0);
        reset       = 1'b0;
        downloading = 1'b1;
        // Small windows for the readable regions so reads find written bytes
        for (int n = 0; n < 200; n++) begin
            case (rand_below(6))
                0: a = `BANK_ADDR + rand_below(64);
                1: a = `SND_ADDR + rand_below(64);
                2: a = `CHAR_ADDR + rand_below(64);
                3: a = `SCRZW_ADDR + rand_below(`OBJWZ_ADDR - `SCRZW_ADDR);
                4: a = `OBJWZ_ADDR + rand_below(64);
                default: a = `PROM_ADDR + rand_below(22'h3F_FFFF - `PROM_ADDR + 1);
            endcase
            write_byte(a, rand_below(256));
        end
        @(negedge clk);
        downloading = 1'b0;
        for (int n = 1; n <= `RST_TAIL; n++) begin
            @(negedge clk);
            check_bit("game_rst tail", n < `RST_TAIL, game_rst);
        end
        priority_read(rand_below(64), rand_below(32));
        for (int n = 0; n < 300; n++) begin
            slot = rand_below(4);
            ra   = rand_below(slot == 3 ? 32 : 64);
            read_slot(slot, ra, 1'b0);
            if (rand_below(3) == 0) begin
                if (slot == 3)
                    ra = ra ^ 18'd1;
                else
                    ra[1:0] = ra[1:0] + 2'(1 + rand_below(3));   // Other lane in the same word
                read_slot(slot, ra, 1'b1);
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
